/* logic/drac_pkg.sv */
// Shared types of the commit stage. RV64 only, xlen is fixed at 64
// The payload of an entry holds either a result or exception info, never both

`default_nettype none

package drac_pkg;

    // Word widths
    localparam int xlen          = 64;
    localparam int exc_cause_w   = 8;
    localparam int exc_value_w   = xlen - exc_cause_w;  // Trap value shares the payload word
    localparam int phys_reg_w    = 6;

    // Writeback ports into the graduation list
    localparam int num_scalar_wb = 2;

    // Coarse instruction classes seen by commit
    typedef enum logic [2:0] {
        alu   = 3'd0,
        load  = 3'd1,
        store = 3'd2,   // Finished at dispatch
        amo   = 3'd3,   // Finished at dispatch
        csr   = 3'd4,
        fence = 3'd5
    } instr_type_t;

    // Exception record, packed so it fills exactly one xlen word
    typedef struct packed {
        logic [exc_cause_w-1:0] cause;
        logic [exc_value_w-1:0] value;
    } exc_info_t;

    // One payload word, read as result or as exception record
    // exception_valid of the entry tells which view is live
    typedef union packed {
        logic [xlen-1:0] result;
        exc_info_t       exc;
    } gl_payload_u;

    // Graduation list entry, also used for dispatch, writeback and commit
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        instr_type_t           instr_type;
        logic [phys_reg_w-1:0] old_prd;          // Previous mapping, freed at commit
        logic                  stall_csr_fence;  // Commit alone, hold successor
        logic                  exception_valid;
        gl_payload_u           payload;
    } gl_instruction_t;

endpackage

`default_nettype wire

/* logic/graduation_list.sv */
// In-order graduation list. num_entries must be a power of two, at least 4
// Writebacks to indices outside the live window are not filtered
// A branch flush assumes flush_index_i lies inside the live window

`default_nettype none

module graduation_list #(
    parameter int  num_entries = 8,
    localparam int idx_w       = $clog2(num_entries),
    localparam int cnt_w       = idx_w + 1
) (
    input  logic                                                    clk_i,
    input  logic                                                    rstn_i,

    // Dispatch at the tail
    input  drac_pkg::gl_instruction_t                               instruction_i,

    // Head read request from commit control
    input  logic                                                    read_head_i,

    // Writeback marking
    input  logic [drac_pkg::num_scalar_wb-1:0][idx_w-1:0]           instruction_writeback_i,
    input  logic [drac_pkg::num_scalar_wb-1:0]                      instruction_writeback_enable_i,
    input  drac_pkg::gl_instruction_t [drac_pkg::num_scalar_wb-1:0] instruction_writeback_data_i,

    // Flushes
    input  logic                                                    flush_i,        // Branch cut
    input  logic [idx_w-1:0]                                        flush_index_i,  // Last kept
    input  logic                                                    flush_commit_i, // Drop all

    output logic [idx_w-1:0]                                        assigned_gl_entry_o,
    output drac_pkg::gl_instruction_t                               instruction_o,
    output logic [idx_w-1:0]                                        commit_gl_entry_o,
    output logic                                                    full_o,
    output logic                                                    empty_o
);

    localparam logic [cnt_w-1:0] full_count = cnt_w'(num_entries);

    // Storage
    drac_pkg::gl_instruction_t entries [num_entries];
    logic [num_entries-1:0]    finished_q;          // Entry may leave the head

    // Pointers, count is one bit wider to tell full from empty
    logic [idx_w-1:0] head_q;
    logic [idx_w-1:0] tail_q;
    logic [cnt_w-1:0] count_q;

    logic             write_en;
    logic             read_en;
    logic             is_store_or_amo;

    // Branch flush recount
    logic [idx_w-1:0] head_adv;
    logic [idx_w-1:0] tail_cut;
    logic [idx_w-1:0] kept_span;
    logic [cnt_w-1:0] count_after_read;
    logic [cnt_w-1:0] flush_count;

    // Registered head output
    drac_pkg::gl_instruction_t out_entry_q;
    logic                      out_valid_q;

    assign full_o  = (count_q == full_count);
    assign empty_o = (count_q == '0);

    assign write_en = instruction_i.valid & ~full_o & ~flush_i & ~flush_commit_i;
    // A branch flush never removes the head, so the read may go ahead with it
    assign read_en  = read_head_i & ~empty_o & finished_q[head_q] & ~flush_commit_i;

    assign is_store_or_amo = instruction_i.instr_type inside {drac_pkg::store, drac_pkg::amo};

    assign head_adv         = head_q + idx_w'(read_en);
    assign tail_cut         = flush_index_i + idx_w'(1);
    assign kept_span        = tail_cut - head_adv;       // Modulo num_entries
    assign count_after_read = count_q - cnt_w'(read_en);

    // A zero span is either an empty window or a full one that was kept whole
    assign flush_count = ((kept_span == '0) && (count_after_read == full_count)) ?
                         full_count : {1'b0, kept_span};

    // Entry payload, written by dispatch and then by writebacks
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail_q] <= instruction_i;
        end
        for (int i = 0; i < drac_pkg::num_scalar_wb; i++) begin
            if (instruction_writeback_enable_i[i]) begin
                // Only the outcome of execution is taken from writeback
                entries[instruction_writeback_i[i]].exception_valid <=
                    instruction_writeback_data_i[i].exception_valid;
                entries[instruction_writeback_i[i]].payload <=
                    instruction_writeback_data_i[i].payload;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finished_q <= '0;
        end else begin
            if (write_en) begin
                finished_q[tail_q] <= is_store_or_amo;
            end
            for (int i = 0; i < drac_pkg::num_scalar_wb; i++) begin
                if (instruction_writeback_enable_i[i]) begin
                    finished_q[instruction_writeback_i[i]] <= 1'b1;
                end
            end
        end
    end

    // Head, tail and count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_commit_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= head_adv;
            tail_q  <= tail_cut;
            count_q <= flush_count;
        end else begin
            head_q  <= head_adv;
            tail_q  <= tail_q + idx_w'(write_en);
            count_q <= count_after_read + cnt_w'(write_en);
        end
    end

    // Head read shows up one cycle later
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= read_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_en) begin
            out_entry_q       <= entries[head_q];
            commit_gl_entry_o <= head_q;
        end
    end

    always_comb begin
        instruction_o       = out_entry_q;
        instruction_o.valid = out_valid_q;    // Only the strobe carries state
    end

    assign assigned_gl_entry_o = tail_q;

endmodule

`default_nettype wire

/* logic/commit_control.sv */
// Commit sequencing for the graduation list head
// One instruction per cycle at most, CSR and fence instructions commit alone
// An exception at commit flushes the whole list in the same cycle

`default_nettype none

module commit_control #(
    parameter int num_entries = 8
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,

    input  drac_pkg::gl_instruction_t commit_instr_i,   // Head output of the list

    output logic                      read_head_o,
    output logic                      flush_commit_o,
    output logic                      retire_o,
    output logic                      trap_o
);

    logic commit_serial;      // Serializing instruction commits this cycle
    logic serial_stall_q;     // Cycle after a serializing commit
    logic commit_exc;

    // The list depth has to wrap cleanly with its pointer width
    if ((num_entries < 4) || ((num_entries & (num_entries - 1)) != 0)) begin : g_bad_depth
        $error("commit_control: num_entries must be a power of two of at least 4");
    end

    assign commit_serial = commit_instr_i.valid & commit_instr_i.stall_csr_fence;
    assign commit_exc    = commit_instr_i.valid & commit_instr_i.exception_valid;

    // Decode the committed instruction
    assign trap_o         = commit_exc;
    assign retire_o       = commit_instr_i.valid & ~commit_instr_i.exception_valid;
    assign flush_commit_o = commit_exc;           // Full flush pulse

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            serial_stall_q <= 1'b0;
        end else begin
            serial_stall_q <= commit_serial;
        end
    end

    // A read in the commit cycle of a serializing instruction would put its
    // successor on the output in the very next cycle, so that read is held too
    always_comb begin
        read_head_o = 1'b1;
        if (flush_commit_o) begin
            read_head_o = 1'b0;               // List is being emptied
        end else if (commit_serial || serial_stall_q) begin
            read_head_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/commit_csr_file.sv */
// Commit side CSRs: trap PC, cause, trap value and retired count
// Cause and trap value are zero-extended from the exception record
// No software write port, the registers only change at commit

`default_nettype none

module commit_csr_file (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  drac_pkg::gl_instruction_t   commit_instr_i,
    input  logic                        retire_i,       // Commit without exception
    input  logic                        trap_i,         // Commit with exception

    output logic [drac_pkg::xlen-1:0]   trap_pc_o,
    output logic [drac_pkg::xlen-1:0]   trap_cause_o,
    output logic [drac_pkg::xlen-1:0]   trap_value_o,
    output logic [drac_pkg::xlen-1:0]   retired_o
);

    // Everything captured on one trap
    typedef struct packed {
        logic [drac_pkg::xlen-1:0]        pc;
        logic [drac_pkg::exc_cause_w-1:0] cause;
        logic [drac_pkg::exc_value_w-1:0] value;
    } trap_rec_t;

    trap_rec_t                 trap_q;
    trap_rec_t                 trap_nx;
    logic [drac_pkg::xlen-1:0] retired_q;

    // Exception view of the payload
    always_comb begin
        trap_nx.pc    = commit_instr_i.pc;
        trap_nx.cause = commit_instr_i.payload.exc.cause;
        trap_nx.value = commit_instr_i.payload.exc.value;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            trap_q <= '0;
        end else if (trap_i) begin
            trap_q <= trap_nx;
        end
    end

    // Retired instruction counter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            retired_q <= '0;
        end else if (retire_i) begin
            retired_q <= retired_q + drac_pkg::xlen'(1);
        end
    end

    assign trap_pc_o    = trap_q.pc;
    assign trap_cause_o = drac_pkg::xlen'(trap_q.cause);
    assign trap_value_o = drac_pkg::xlen'(trap_q.value);
    assign retired_o    = retired_q;

endmodule

`default_nettype wire

/* logic/graduation_commit_top.sv */
// Commit stage: graduation list, commit control and commit CSRs
// Dispatch must not be sent while full_o is high, it is dropped otherwise

`default_nettype none

module graduation_commit_top #(
    parameter int  num_entries = 8,
    localparam int idx_w       = $clog2(num_entries)
) (
    input  logic                                                    clk_i,
    input  logic                                                    rstn_i,

    // Dispatch
    input  drac_pkg::gl_instruction_t                               dispatch_i,
    output logic [idx_w-1:0]                                        assigned_gl_entry_o,
    output logic                                                    full_o,
    output logic                                                    empty_o,

    // Writeback
    input  logic [drac_pkg::num_scalar_wb-1:0][idx_w-1:0]           wb_index_i,
    input  logic [drac_pkg::num_scalar_wb-1:0]                      wb_enable_i,
    input  drac_pkg::gl_instruction_t [drac_pkg::num_scalar_wb-1:0] wb_data_i,

    // Branch flush
    input  logic                                                    flush_i,
    input  logic [idx_w-1:0]                                        flush_index_i,

    // Commit
    output drac_pkg::gl_instruction_t                               commit_o,
    output logic [idx_w-1:0]                                        commit_gl_entry_o,
    output logic                                                    flush_commit_o,

    // Commit CSRs
    output logic [drac_pkg::xlen-1:0]                               trap_pc_o,
    output logic [drac_pkg::xlen-1:0]                               trap_cause_o,
    output logic [drac_pkg::xlen-1:0]                               trap_value_o,
    output logic [drac_pkg::xlen-1:0]                               retired_o
);

    logic read_head;
    logic retire;
    logic trap;

    graduation_list #(
        .num_entries(num_entries)
    ) u_graduation_list (
        .clk_i                          (clk_i),
        .rstn_i                         (rstn_i),
        .instruction_i                  (dispatch_i),
        .read_head_i                    (read_head),
        .instruction_writeback_i        (wb_index_i),
        .instruction_writeback_enable_i (wb_enable_i),
        .instruction_writeback_data_i   (wb_data_i),
        .flush_i                        (flush_i),
        .flush_index_i                  (flush_index_i),
        .flush_commit_i                 (flush_commit_o),
        .assigned_gl_entry_o            (assigned_gl_entry_o),
        .instruction_o                  (commit_o),         // Head output is the commit port
        .commit_gl_entry_o              (commit_gl_entry_o),
        .full_o                         (full_o),
        .empty_o                        (empty_o)
    );

    commit_control #(
        .num_entries(num_entries)
    ) u_commit_control (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .commit_instr_i (commit_o),
        .read_head_o    (read_head),
        .flush_commit_o (flush_commit_o),
        .retire_o       (retire),
        .trap_o         (trap)
    );

    commit_csr_file u_commit_csr_file (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .commit_instr_i (commit_o),
        .retire_i       (retire),
        .trap_i         (trap),
        .trap_pc_o      (trap_pc_o),
        .trap_cause_o   (trap_cause_o),
        .trap_value_o   (trap_value_o),
        .retired_o      (retired_o)
    );

endmodule

`default_nettype wire

/* testbench/graduation_commit_asserts.sv */
// Concurrent checks on the flag and flush rules of the commit stage
// Checks are off while reset is low

`default_nettype none

module graduation_commit_asserts (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  drac_pkg::gl_instruction_t dispatch_i,
    input  drac_pkg::gl_instruction_t commit_o,
    input  logic                      flush_commit_o,
    input  logic                      full_o,
    input  logic                      empty_o
);

    int fail_count = 0;    // Failed checks so far

    property full_empty_exclusive;
        @(posedge clk_i) disable iff (!rstn_i) !(full_o && empty_o);
    endproperty

    property flush_needs_exception;
        @(posedge clk_i) disable iff (!rstn_i)
            flush_commit_o |-> (commit_o.valid && commit_o.exception_valid);
    endproperty

    // The list is emptied so nothing may leave the head right after
    property quiet_after_flush;
        @(posedge clk_i) disable iff (!rstn_i) flush_commit_o |=> !commit_o.valid;
    endproperty

    property no_dispatch_when_full;
        @(posedge clk_i) disable iff (!rstn_i) full_o |-> !dispatch_i.valid;
    endproperty

    a_full_empty: assert property (full_empty_exclusive)
        else begin
            fail_count++;
            $error("full_o and empty_o high together");
        end
    a_flush_exc: assert property (flush_needs_exception)
        else begin
            fail_count++;
            $error("flush_commit_o without a committed exception");
        end
    a_quiet: assert property (quiet_after_flush)
        else begin
            fail_count++;
            $error("commit_o.valid in the cycle after a full flush");
        end
    a_dispatch: assert property (no_dispatch_when_full)
        else begin
            fail_count++;
            $error("dispatch sent while full_o is high");
        end

endmodule

bind graduation_commit_top graduation_commit_asserts u_asserts (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .dispatch_i     (dispatch_i),
    .commit_o       (commit_o),
    .flush_commit_o (flush_commit_o),
    .full_o         (full_o),
    .empty_o        (empty_o)
);

`default_nettype wire

/* testbench/tb_graduation_commit.sv */
// Random dispatch, shuffled writebacks and branch flushes against a queue model
// Runs with an 8 entry list and stops at the first mismatch

`default_nettype none

module tb_graduation_commit;

    localparam int n_entries = 8;
    localparam int stim_cycles = 700;

    logic clk_i = 1'b0;
    logic rstn_i;
    drac_pkg::gl_instruction_t dispatch_i;
    logic [2:0] assigned_gl_entry_o;
    logic full_o, empty_o;
    logic [drac_pkg::num_scalar_wb-1:0][2:0] wb_index_i;
    logic [drac_pkg::num_scalar_wb-1:0] wb_enable_i;
    drac_pkg::gl_instruction_t [drac_pkg::num_scalar_wb-1:0] wb_data_i;
    logic flush_i;
    logic [2:0] flush_index_i;
    drac_pkg::gl_instruction_t commit_o;
    logic [2:0] commit_gl_entry_o;
    logic flush_commit_o;
    logic [63:0] trap_pc_o, trap_cause_o, trap_value_o, retired_o;

    // Reference model per entry plus program order of live entries
    logic [63:0] pc_of [n_entries];
    logic [63:0] word_of [n_entries];
    drac_pkg::instr_type_t type_of [n_entries];
    logic [5:0] prd_of [n_entries];
    logic done_of [n_entries];
    logic exc_of [n_entries];
    logic serial_of [n_entries];
    int order_q[$];
    int cand_q[$];
    int cycle_count = 0;

    graduation_commit_top #(.num_entries(n_entries)) UUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= 4000) begin
            $display("timeout: the test did not finish within 4000 cycles");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic mismatch_fail(string name, logic [63:0] exp, logic [63:0] act);
        $display("error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(string msg);
        $display("%s at time %0t", msg, $time);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    initial begin
        integer seed;
        logic [2:0] tail_exp;
        logic [63:0] retired_exp, trap_pc_exp, trap_word_exp;
        logic prev_serial, trap_pending, exc_now;
        int head, k, e, cyc;

        seed = 32'hc205_ab6d;
        rstn_i = 1'b0;
        dispatch_i = '0;
        wb_index_i = '0;
        wb_enable_i = '0;
        wb_data_i = '0;
        flush_i = 1'b0;
        flush_index_i = '0;
        tail_exp = '0;
        retired_exp = '0;
        trap_pc_exp = '0;
        trap_word_exp = '0;
        prev_serial = 1'b0;
        trap_pending = 1'b0;
        cyc = 0;
        repeat (16) @(posedge clk_i);
        assert (!commit_o.valid && !flush_commit_o && !full_o && empty_o)
            else abort_run("flags wrong during reset");
        assert (trap_pc_o == 0 && trap_cause_o == 0 && trap_value_o == 0 && retired_o == 0)
            else abort_run("CSR registers not zero during reset");
        #1 rstn_i = 1'b1;

        while (cyc < stim_cycles || order_q.size() > 0 || trap_pending) begin
            @(posedge clk_i);
            #1;
            cyc++;
            dispatch_i = '0;
            wb_enable_i = '0;
            flush_i = 1'b0;
            assert (retired_o == retired_exp)
                else mismatch_fail("retired_o", retired_exp, retired_o);
            if (trap_pending) begin
                assert (empty_o) else mismatch_fail("empty_o", 1, empty_o);
                assert (trap_pc_o == trap_pc_exp)
                    else mismatch_fail("trap_pc_o", trap_pc_exp, trap_pc_o);
                assert (trap_cause_o == 64'(trap_word_exp[63:56]))
                    else mismatch_fail("trap_cause_o", 64'(trap_word_exp[63:56]), trap_cause_o);
                assert (trap_value_o == 64'(trap_word_exp[55:0]))
                    else mismatch_fail("trap_value_o", 64'(trap_word_exp[55:0]), trap_value_o);
                trap_pending = 1'b0;
            end
            exc_now = 1'b0;
            if (commit_o.valid) begin
                assert (!prev_serial) else abort_run("commit right after a CSR or fence commit");
                assert (order_q.size() > 0)
                    else abort_run("commit with no live entry in the model");
                head = order_q.pop_front();
                assert (commit_gl_entry_o == 3'(head))
                    else mismatch_fail("commit_gl_entry_o", head, commit_gl_entry_o);
                assert (commit_o.pc == pc_of[head])
                    else mismatch_fail("commit_o.pc", pc_of[head], commit_o.pc);
                assert (commit_o.instr_type == type_of[head])
                    else mismatch_fail("commit_o.instr_type", type_of[head], commit_o.instr_type);
                assert (commit_o.old_prd == prd_of[head])
                    else mismatch_fail("commit_o.old_prd", prd_of[head], commit_o.old_prd);
                assert (commit_o.stall_csr_fence == serial_of[head])
                    else mismatch_fail("commit_o.stall_csr_fence", serial_of[head],
                                       commit_o.stall_csr_fence);
                assert (done_of[head]) else abort_run("entry committed before its writeback");
                assert (commit_o.exception_valid == exc_of[head])
                    else mismatch_fail("commit_o.exception_valid", exc_of[head], commit_o.exception_valid);
                assert (commit_o.payload == word_of[head])
                    else mismatch_fail("commit_o.payload", word_of[head], commit_o.payload);
                assert (flush_commit_o == exc_of[head])
                    else mismatch_fail("flush_commit_o", exc_of[head], flush_commit_o);
                exc_now = exc_of[head];
                if (!exc_now) retired_exp++;
                prev_serial = serial_of[head];
            end else begin
                assert (!flush_commit_o) else mismatch_fail("flush_commit_o", 0, flush_commit_o);
                prev_serial = 1'b0;
            end
            assert (full_o == (order_q.size() == n_entries))
                else mismatch_fail("full_o", order_q.size() == n_entries, full_o);
            assert (empty_o == (order_q.size() == 0))
                else mismatch_fail("empty_o", order_q.size() == 0, empty_o);
            assert (UUT.u_asserts.fail_count == 0) else abort_run("a bound assertion failed");

            if (exc_now) begin       // List empties on this edge
                trap_pending = 1'b1;
                trap_pc_exp = pc_of[head];
                trap_word_exp = word_of[head];
                order_q.delete();
                tail_exp = '0;
            end else if (cyc < stim_cycles && order_q.size() > 0 &&
                         ($unsigned($random(seed)) % 16) == 0) begin
                k = $unsigned($random(seed)) % order_q.size();
                flush_i = 1'b1;
                flush_index_i = 3'(order_q[k]);
                while (order_q.size() > k + 1) order_q.delete(order_q.size() - 1);
                tail_exp = 3'(order_q[k] + 1);
            end else begin
                cand_q.delete();
                foreach (order_q[i]) begin
                    if (!done_of[order_q[i]]) cand_q.push_back(order_q[i]);
                end
                for (int p = 0; p < drac_pkg::num_scalar_wb; p++) begin
                    if (cand_q.size() > 0 && ($unsigned($random(seed)) % 3) != 0) begin
                        k = $unsigned($random(seed)) % cand_q.size();
                        e = cand_q[k];
                        cand_q.delete(k);
                        wb_enable_i[p] = 1'b1;
                        wb_index_i[p] = 3'(e);
                        wb_data_i[p].exception_valid = (($unsigned($random(seed)) % 8) == 0);
                        wb_data_i[p].payload = {$random(seed), $random(seed)};
                        done_of[e] = 1'b1;
                        exc_of[e] = wb_data_i[p].exception_valid;
                        word_of[e] = wb_data_i[p].payload;
                    end
                end
                if (cyc < stim_cycles && !full_o && ($unsigned($random(seed)) % 4) != 0) begin
                    assert (assigned_gl_entry_o == tail_exp)
                        else mismatch_fail("assigned_gl_entry_o", tail_exp, assigned_gl_entry_o);
                    e = tail_exp;
                    dispatch_i.valid = 1'b1;
                    dispatch_i.pc = 64'h8000_0000 + 64'(cyc * 4);
                    dispatch_i.instr_type =
                        drac_pkg::instr_type_t'($unsigned($random(seed)) % 6);
                    dispatch_i.old_prd = 6'($random(seed));
                    dispatch_i.stall_csr_fence =
                        dispatch_i.instr_type inside {drac_pkg::csr, drac_pkg::fence};
                    dispatch_i.payload = {$random(seed), $random(seed)};
                    pc_of[e] = dispatch_i.pc;
                    word_of[e] = dispatch_i.payload;
                    type_of[e] = dispatch_i.instr_type;
                    prd_of[e] = dispatch_i.old_prd;
                    exc_of[e] = 1'b0;
                    serial_of[e] = dispatch_i.stall_csr_fence;
                    done_of[e] = dispatch_i.instr_type inside {drac_pkg::store, drac_pkg::amo};
                    order_q.push_back(e);
                    tail_exp = tail_exp + 3'd1;
                end
            end
        end

        repeat (2) @(posedge clk_i);
        if (UUT.u_asserts.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* drac_commit.f */
logic/drac_pkg.sv
logic/graduation_list.sv
logic/commit_control.sv
logic/commit_csr_file.sv
logic/graduation_commit_top.sv
testbench/graduation_commit_asserts.sv
testbench/tb_graduation_commit.sv

/* Makefile */
# Verilator build and run of the commit stage testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module tb_graduation_commit \
		-f drac_commit.f --Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
